// File: common/lc3b_isa_pkg.sv
`default_nettype none

package lc3b_isa_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;

    // Low bit of each instruction field
    localparam int OPCODE_LSB = 12;
    localparam int DR_LSB     = 9;
    localparam int SR1_LSB    = 6;
    localparam int SR2_LSB    = 0;
    localparam int IMM_FLAG   = 5;

    // Opcodes not listed here decode as no-ops
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

endpackage

`default_nettype wire

// File: common/lc3b_ctrl_pkg.sv
`default_nettype none

package lc3b_ctrl_pkg;

    typedef enum logic [3:0] {
        fetch1,
        fetch2,
        fetch3,
        decode,
        s_add,
        s_and,
        s_not,
        br,
        br_taken,
        calc_addr,
        ldr1,
        ldr2,
        str1,
        str2
    } ctrl_state;

    typedef enum logic {pc_plus2, pc_branch} pc_sel;

    // Encoding matches the ALU B mux wiring
    typedef enum logic [1:0] {
        alu_b_reg  = 2'b00,
        alu_b_off6 = 2'b01,
        alu_b_imm5 = 2'b10
    } alu_b_sel;

    typedef enum logic {mar_alu, mar_pc} mar_sel;
    typedef enum logic {mdr_alu, mdr_mem} mdr_sel;
    typedef enum logic {rf_alu, rf_mdr} rf_sel;
    typedef enum logic {store_sr1, store_dr} store_sel;

endpackage

`default_nettype wire

// File: datapath/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  var  lc3b_isa_pkg::lc3b_aluop aluop,
    input  wire lc3b_isa_pkg::lc3b_word  a,
    input  wire lc3b_isa_pkg::lc3b_word  b,
    output lc3b_isa_pkg::lc3b_word       f
);

    always_comb begin
        case (aluop)
            lc3b_isa_pkg::alu_add:  f = a + b;
            lc3b_isa_pkg::alu_and:  f = a & b;
            lc3b_isa_pkg::alu_not:  f = ~a;
            // Pass feeds the store data path
            lc3b_isa_pkg::alu_pass: f = a;
            default:                f = a;
        endcase
    end

endmodule

`default_nettype wire

// File: datapath/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          load,
    input  wire lc3b_isa_pkg::lc3b_reg   src_a,
    input  wire lc3b_isa_pkg::lc3b_reg   src_b,
    input  wire lc3b_isa_pkg::lc3b_reg   dest,
    input  wire lc3b_isa_pkg::lc3b_word  in,
    output lc3b_isa_pkg::lc3b_word       reg_a,
    output lc3b_isa_pkg::lc3b_word       reg_b
);

    lc3b_isa_pkg::lc3b_word regs [8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    // Reads see the old value during a write cycle
    assign reg_a = regs[src_a];
    assign reg_b = regs[src_b];

endmodule

`default_nettype wire

// File: datapath/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             load_pc,
    input  wire                             load_ir,
    input  wire                             load_regfile,
    input  wire                             load_mar,
    input  wire                             load_mdr,
    input  wire                             load_cc,
    input  var  lc3b_ctrl_pkg::pc_sel       pcmux_sel,
    input  var  lc3b_ctrl_pkg::store_sel    storemux_sel,
    input  var  lc3b_ctrl_pkg::alu_b_sel    alumux_sel,
    input  var  lc3b_ctrl_pkg::rf_sel       regfilemux_sel,
    input  var  lc3b_ctrl_pkg::mar_sel      marmux_sel,
    input  var  lc3b_ctrl_pkg::mdr_sel      mdrmux_sel,
    input  var  lc3b_isa_pkg::lc3b_aluop    aluop,
    input  wire lc3b_isa_pkg::lc3b_word     mem_rdata,
    output lc3b_isa_pkg::lc3b_opcode        opcode,
    output logic                            inst5,
    output logic                            branch_enable,
    output lc3b_isa_pkg::lc3b_word          mem_address,
    output lc3b_isa_pkg::lc3b_word          mem_wdata
);

    lc3b_isa_pkg::lc3b_word pc;
    lc3b_isa_pkg::lc3b_word ir;
    lc3b_isa_pkg::lc3b_word mar;
    lc3b_isa_pkg::lc3b_word mdr;
    logic [2:0]             cc;
    logic [2:0]             cc_next;
    lc3b_isa_pkg::lc3b_word pc_next;
    lc3b_isa_pkg::lc3b_word off9;
    lc3b_isa_pkg::lc3b_word off6;
    lc3b_isa_pkg::lc3b_word imm5;
    lc3b_isa_pkg::lc3b_word reg_a;
    lc3b_isa_pkg::lc3b_word reg_b;
    lc3b_isa_pkg::lc3b_word alu_b;
    lc3b_isa_pkg::lc3b_word alu_f;
    lc3b_isa_pkg::lc3b_word rf_in;
    lc3b_isa_pkg::lc3b_reg  src_a;
    lc3b_isa_pkg::lc3b_reg  dest;

    // Offsets are word-scaled except imm5
    assign off9 = {{6{ir[8]}}, ir[8:0], 1'b0};
    assign off6 = {{9{ir[5]}}, ir[5:0], 1'b0};
    assign imm5 = {{11{ir[4]}}, ir[4:0]};

    assign dest  = ir[lc3b_isa_pkg::DR_LSB +: 3];
    assign src_a = (storemux_sel == lc3b_ctrl_pkg::store_dr) ? dest
                                                               : ir[lc3b_isa_pkg::SR1_LSB +: 3];

    // PC already holds the incremented value when a branch is taken
    assign pc_next = (pcmux_sel == lc3b_ctrl_pkg::pc_branch) ? pc + off9 : pc + 16'd2;

    always_comb begin
        case (alumux_sel)
            lc3b_ctrl_pkg::alu_b_off6: alu_b = off6;
            lc3b_ctrl_pkg::alu_b_imm5: alu_b = imm5;
            default:                   alu_b = reg_b;
        endcase
    end

    assign rf_in = (regfilemux_sel == lc3b_ctrl_pkg::rf_mdr) ? mdr : alu_f;

    // nzp from the value being written back
    assign cc_next = rf_in[15] ? 3'b100 : (rf_in == '0) ? 3'b010 : 3'b001;

    regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (load_regfile),
        .src_a  (src_a),
        .src_b  (ir[lc3b_isa_pkg::SR2_LSB +: 3]),
        .dest   (dest),
        .in     (rf_in),
        .reg_a  (reg_a),
        .reg_b  (reg_b)
    );

    alu u_alu (
        .aluop (aluop),
        .a     (reg_a),
        .b     (alu_b),
        .f     (alu_f)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
            cc <= 3'b010;
        end else begin
            if (load_pc) begin
                pc <= pc_next;
            end
            if (load_cc) begin
                cc <= cc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_ir) begin
            ir <= mdr;
        end
        if (load_mar) begin
            mar <= (marmux_sel == lc3b_ctrl_pkg::mar_pc) ? pc : alu_f;
        end
        if (load_mdr) begin
            mdr <= (mdrmux_sel == lc3b_ctrl_pkg::mdr_mem) ? mem_rdata : alu_f;
        end
    end

    assign opcode        = lc3b_isa_pkg::lc3b_opcode'(ir[lc3b_isa_pkg::OPCODE_LSB +: 4]);
    assign inst5         = ir[lc3b_isa_pkg::IMM_FLAG];
    assign branch_enable = |(ir[11:9] & cc);
    assign mem_address   = mar;
    assign mem_wdata     = mdr;

endmodule

`default_nettype wire

// File: hw/control.sv
`timescale 1ns/1ps
`default_nettype none

module control (
    input  wire                             clk,
    input  wire                             arst_n,
    input  var  lc3b_isa_pkg::lc3b_opcode   opcode,
    input  wire                             inst5,
    input  wire                             branch_enable,
    input  wire                             mem_resp,
    output logic                            load_pc,
    output logic                            load_ir,
    output logic                            load_regfile,
    output logic                            load_mar,
    output logic                            load_mdr,
    output logic                            load_cc,
    output lc3b_ctrl_pkg::pc_sel            pcmux_sel,
    output lc3b_ctrl_pkg::store_sel         storemux_sel,
    output lc3b_ctrl_pkg::alu_b_sel         alumux_sel,
    output lc3b_ctrl_pkg::rf_sel            regfilemux_sel,
    output lc3b_ctrl_pkg::mar_sel           marmux_sel,
    output lc3b_ctrl_pkg::mdr_sel           mdrmux_sel,
    output lc3b_isa_pkg::lc3b_aluop         aluop,
    output logic                            mem_read,
    output logic                            mem_write
);

    lc3b_ctrl_pkg::ctrl_state state;
    lc3b_ctrl_pkg::ctrl_state next_state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= lc3b_ctrl_pkg::fetch1;
        end else begin
            state <= next_state;
        end
    end

    // Moore outputs, one set per state
    always_comb begin
        load_pc        = 1'b0;
        load_ir        = 1'b0;
        load_regfile   = 1'b0;
        load_mar       = 1'b0;
        load_mdr       = 1'b0;
        load_cc        = 1'b0;
        pcmux_sel      = lc3b_ctrl_pkg::pc_plus2;
        storemux_sel   = lc3b_ctrl_pkg::store_sr1;
        alumux_sel     = lc3b_ctrl_pkg::alu_b_reg;
        regfilemux_sel = lc3b_ctrl_pkg::rf_alu;
        marmux_sel     = lc3b_ctrl_pkg::mar_alu;
        mdrmux_sel     = lc3b_ctrl_pkg::mdr_alu;
        aluop          = lc3b_isa_pkg::alu_add;
        mem_read       = 1'b0;
        mem_write      = 1'b0;

        case (state)
            lc3b_ctrl_pkg::fetch1: begin
                // MAR <- PC, PC <- PC + 2
                marmux_sel = lc3b_ctrl_pkg::mar_pc;
                load_mar   = 1'b1;
                load_pc    = 1'b1;
            end
            lc3b_ctrl_pkg::fetch2, lc3b_ctrl_pkg::ldr1: begin
                // MDR reloads each wait cycle and keeps the response word
                mem_read   = 1'b1;
                mdrmux_sel = lc3b_ctrl_pkg::mdr_mem;
                load_mdr   = 1'b1;
            end
            lc3b_ctrl_pkg::fetch3: begin
                load_ir = 1'b1;
            end
            lc3b_ctrl_pkg::s_add, lc3b_ctrl_pkg::s_and: begin
                if (inst5) begin
                    alumux_sel = lc3b_ctrl_pkg::alu_b_imm5;
                end
                if (state == lc3b_ctrl_pkg::s_and) begin
                    aluop = lc3b_isa_pkg::alu_and;
                end
                load_cc      = 1'b1;
                load_regfile = 1'b1;
            end
            lc3b_ctrl_pkg::s_not: begin
                aluop        = lc3b_isa_pkg::alu_not;
                load_cc      = 1'b1;
                load_regfile = 1'b1;
            end
            lc3b_ctrl_pkg::br_taken: begin
                pcmux_sel = lc3b_ctrl_pkg::pc_branch;
                load_pc   = 1'b1;
            end
            lc3b_ctrl_pkg::calc_addr: begin
                // MAR <- base + sext(offset6) << 1
                alumux_sel = lc3b_ctrl_pkg::alu_b_off6;
                load_mar   = 1'b1;
            end
            lc3b_ctrl_pkg::ldr2: begin
                regfilemux_sel = lc3b_ctrl_pkg::rf_mdr;
                load_cc        = 1'b1;
                load_regfile   = 1'b1;
            end
            lc3b_ctrl_pkg::str1: begin
                // Source register comes through port A from IR[11:9]
                storemux_sel = lc3b_ctrl_pkg::store_dr;
                aluop        = lc3b_isa_pkg::alu_pass;
                load_mdr     = 1'b1;
            end
            lc3b_ctrl_pkg::str2: begin
                mem_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        next_state = lc3b_ctrl_pkg::fetch1;
        case (state)
            lc3b_ctrl_pkg::fetch1:   next_state = lc3b_ctrl_pkg::fetch2;
            lc3b_ctrl_pkg::fetch2: begin
                next_state = mem_resp ? lc3b_ctrl_pkg::fetch3 : lc3b_ctrl_pkg::fetch2;
            end
            lc3b_ctrl_pkg::fetch3:   next_state = lc3b_ctrl_pkg::decode;
            lc3b_ctrl_pkg::decode: begin
                case (opcode)
                    lc3b_isa_pkg::op_add: next_state = lc3b_ctrl_pkg::s_add;
                    lc3b_isa_pkg::op_and: next_state = lc3b_ctrl_pkg::s_and;
                    lc3b_isa_pkg::op_not: next_state = lc3b_ctrl_pkg::s_not;
                    lc3b_isa_pkg::op_br:  next_state = lc3b_ctrl_pkg::br;
                    lc3b_isa_pkg::op_ldr: next_state = lc3b_ctrl_pkg::calc_addr;
                    lc3b_isa_pkg::op_str: next_state = lc3b_ctrl_pkg::calc_addr;
                    // Anything else is a no-op
                    default:              next_state = lc3b_ctrl_pkg::fetch1;
                endcase
            end
            lc3b_ctrl_pkg::br: begin
                next_state = branch_enable ? lc3b_ctrl_pkg::br_taken : lc3b_ctrl_pkg::fetch1;
            end
            lc3b_ctrl_pkg::calc_addr: begin
                if (opcode == lc3b_isa_pkg::op_ldr) begin
                    next_state = lc3b_ctrl_pkg::ldr1;
                end else begin
                    next_state = lc3b_ctrl_pkg::str1;
                end
            end
            lc3b_ctrl_pkg::ldr1: begin
                next_state = mem_resp ? lc3b_ctrl_pkg::ldr2 : lc3b_ctrl_pkg::ldr1;
            end
            lc3b_ctrl_pkg::str1:     next_state = lc3b_ctrl_pkg::str2;
            lc3b_ctrl_pkg::str2: begin
                next_state = mem_resp ? lc3b_ctrl_pkg::fetch1 : lc3b_ctrl_pkg::str2;
            end
            default:                 next_state = lc3b_ctrl_pkg::fetch1;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          mem_resp,
    input  wire lc3b_isa_pkg::lc3b_word  mem_rdata,
    output logic                         mem_read,
    output logic                         mem_write,
    output lc3b_isa_pkg::lc3b_word       mem_address,
    output lc3b_isa_pkg::lc3b_word       mem_wdata
);

    logic                        load_pc;
    logic                        load_ir;
    logic                        load_regfile;
    logic                        load_mar;
    logic                        load_mdr;
    logic                        load_cc;
    lc3b_ctrl_pkg::pc_sel        pcmux_sel;
    lc3b_ctrl_pkg::store_sel     storemux_sel;
    lc3b_ctrl_pkg::alu_b_sel     alumux_sel;
    lc3b_ctrl_pkg::rf_sel        regfilemux_sel;
    lc3b_ctrl_pkg::mar_sel       marmux_sel;
    lc3b_ctrl_pkg::mdr_sel       mdrmux_sel;
    lc3b_isa_pkg::lc3b_aluop     aluop;
    lc3b_isa_pkg::lc3b_opcode    opcode;
    logic                        inst5;
    logic                        branch_enable;

    control u_control (
        .clk            (clk),
        .arst_n         (arst_n),
        .opcode         (opcode),
        .inst5          (inst5),
        .branch_enable  (branch_enable),
        .mem_resp       (mem_resp),
        .load_pc        (load_pc),
        .load_ir        (load_ir),
        .load_regfile   (load_regfile),
        .load_mar       (load_mar),
        .load_mdr       (load_mdr),
        .load_cc        (load_cc),
        .pcmux_sel      (pcmux_sel),
        .storemux_sel   (storemux_sel),
        .alumux_sel     (alumux_sel),
        .regfilemux_sel (regfilemux_sel),
        .marmux_sel     (marmux_sel),
        .mdrmux_sel     (mdrmux_sel),
        .aluop          (aluop),
        .mem_read       (mem_read),
        .mem_write      (mem_write)
    );

    datapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk            (clk),
        .arst_n         (arst_n),
        .load_pc        (load_pc),
        .load_ir        (load_ir),
        .load_regfile   (load_regfile),
        .load_mar       (load_mar),
        .load_mdr       (load_mdr),
        .load_cc        (load_cc),
        .pcmux_sel      (pcmux_sel),
        .storemux_sel   (storemux_sel),
        .alumux_sel     (alumux_sel),
        .regfilemux_sel (regfilemux_sel),
        .marmux_sel     (marmux_sel),
        .mdrmux_sel     (mdrmux_sel),
        .aluop          (aluop),
        .mem_rdata      (mem_rdata),
        .opcode         (opcode),
        .inst5          (inst5),
        .branch_enable  (branch_enable),
        .mem_address    (mem_address),
        .mem_wdata      (mem_wdata)
    );

endmodule

`default_nettype wire

// File: sim/tb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          mem_read,
    input  wire                          mem_write,
    input  wire lc3b_isa_pkg::lc3b_word  mem_address,
    input  wire lc3b_isa_pkg::lc3b_word  mem_wdata,
    output logic                         mem_resp,
    output lc3b_isa_pkg::lc3b_word       mem_rdata
);

    lc3b_isa_pkg::lc3b_word words [256];
    logic [31:0]            lcg_state;
    logic [1:0]             wait_count;
    logic [1:0]             wait_target;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Extra wait cycles from 0 to 2
    function automatic logic [1:0] delay_from(input logic [31:0] state);
        logic [31:0] r;
        r = (state >> 16) % 32'd3;
        return r[1:0];
    endfunction

    // Backdoor load before reset is released
    task automatic load_word(input int unsigned index, input lc3b_isa_pkg::lc3b_word value);
        words[index] = value;
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_resp    <= 1'b0;
            mem_rdata   <= '0;
            lcg_state   <= 32'h8c46;
            wait_count  <= '0;
            wait_target <= '0;
        end else begin
            mem_resp <= 1'b0;
            // Strobe stays high through the response cycle, so skip that one
            if ((mem_read || mem_write) && !mem_resp) begin
                if (wait_count == wait_target) begin
                    mem_resp    <= 1'b1;
                    wait_count  <= '0;
                    lcg_state   <= lcg_next(lcg_state);
                    wait_target <= delay_from(lcg_next(lcg_state));
                    if (mem_read) begin
                        mem_rdata <= words[mem_address[8:1]];
                    end else begin
                        words[mem_address[8:1]] <= mem_wdata;
                    end
                end else begin
                    wait_count <= wait_count + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam int          NUM_READS   = 19;
    localparam int          NUM_WRITES  = 8;
    localparam logic [15:0] POISON_ADDR = 16'h003e;
    // Room for 40 instructions with two 3-cycle accesses each
    localparam int          TIMEOUT_CYCLES = 40 * 12;

    logic                   clk;
    logic                   arst_n;
    logic                   mem_resp;
    lc3b_isa_pkg::lc3b_word mem_rdata;
    logic                   mem_read;
    logic                   mem_write;
    lc3b_isa_pkg::lc3b_word mem_address;
    lc3b_isa_pkg::lc3b_word mem_wdata;

    logic [15:0] program_image [NUM_READS];
    logic [15:0] exp_read [NUM_READS];
    logic [15:0] exp_waddr [NUM_WRITES];
    logic [15:0] exp_wdata [NUM_WRITES];
    logic        prev_arst_n;
    logic        prev_read;
    logic        prev_write;
    logic        prev_resp;
    logic [15:0] prev_address;
    logic [15:0] prev_wdata;
    int          read_idx = 0;
    int          write_idx = 0;
    int          cycle_count = 0;

    cpu #(
        .RESET_PC (16'h0000)
    ) dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .mem_resp    (mem_resp),
        .mem_rdata   (mem_rdata),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata)
    );

    tb_memory u_mem (
        .clk         (clk),
        .arst_n      (arst_n),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .mem_resp    (mem_resp),
        .mem_rdata   (mem_rdata)
    );

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        $display("Fail %s: got %h, expected %h", name, got, expected);
        abort_run();
    endtask

    task automatic text_error(input string msg);
        $display("Error: %s", msg);
        abort_run();
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        program_image = '{
            16'h1227,   // 00 ADD R1,R0,#7     R1 = 0007
            16'h147d,   // 02 ADD R2,R1,#-3    R2 = 0004
            16'h1642,   // 04 ADD R3,R1,R2     R3 = 000b
            16'h58c1,   // 06 AND R4,R3,R1     R4 = 0003
            16'h7218,   // 08 STR R1 -> 0030
            16'h7419,   // 0a STR R2 -> 0032
            16'h761a,   // 0c STR R3 -> 0034
            16'h781b,   // 0e STR R4 -> 0036
            16'h54ee,   // 10 AND R2,R3,#14    R2 = 000a
            16'h98ff,   // 12 NOT R4,R3        R4 = fff4, CC n
            16'h0801,   // 14 BRn +1, taken
            16'h781f,   // 16 poison STR -> 003e
            16'h741c,   // 18 STR R2 -> 0038
            16'h781d,   // 1a STR R4 -> 003a
            16'h0601,   // 1c BRzp +1, not taken
            16'h721e,   // 1e STR R1 -> 003c
            16'h6a17,   // 20 LDR R5,R0,#23    R5 = beef from 002e
            16'hd000,   // 22 undefined opcode
            16'h7a16    // 24 STR R5 -> 002c
        };
        exp_read = '{16'h00, 16'h02, 16'h04, 16'h06, 16'h08, 16'h0a, 16'h0c,
                     16'h0e, 16'h10, 16'h12, 16'h14, 16'h18, 16'h1a, 16'h1c,
                     16'h1e, 16'h20, 16'h2e, 16'h22, 16'h24};
        exp_waddr = '{16'h30, 16'h32, 16'h34, 16'h36, 16'h38, 16'h3a, 16'h3c, 16'h2c};
        exp_wdata = '{16'h0007, 16'h0004, 16'h000b, 16'h0003,
                      16'h000a, 16'hfff4, 16'h0007, 16'hbeef};
        for (int i = 0; i < 256; i++) begin
            u_mem.load_word(i, {i[7:0] ^ 8'h5a, i[7:0]});
        end
        for (int i = 0; i < NUM_READS; i++) begin
            u_mem.load_word(i, program_image[i]);
        end
        u_mem.load_word(23, 16'hbeef);
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
    end

    // Protocol checks on values from the previous cycle
    always @(posedge clk) begin
        prev_arst_n  <= arst_n;
        prev_read    <= mem_read;
        prev_write   <= mem_write;
        prev_resp    <= mem_resp;
        prev_address <= mem_address;
        prev_wdata   <= mem_wdata;
        if (!arst_n || !prev_arst_n) begin
            assert (!mem_read && !mem_write)
                else text_error("memory strobe high during or right after reset");
        end
        assert (!(mem_read && mem_write)) else text_error("read and write high together");
        if ((prev_read || prev_write) && !prev_resp) begin
            assert (mem_read == prev_read) else value_error("mem_read", mem_read, prev_read);
            assert (mem_write == prev_write) else value_error("mem_write", mem_write, prev_write);
            assert (mem_address == prev_address)
                else value_error("mem_address", mem_address, prev_address);
            if (prev_write) begin
                assert (mem_wdata == prev_wdata)
                    else value_error("mem_wdata", mem_wdata, prev_wdata);
            end
        end
    end

    // Completed accesses against the hand-worked sequences
    always @(posedge clk) begin
        if (arst_n && mem_read && mem_resp) begin
            assert (read_idx < NUM_READS) else text_error("read past the expected sequence");
            assert (mem_address == exp_read[read_idx])
                else value_error("mem_address", mem_address, exp_read[read_idx]);
            read_idx <= read_idx + 1;
        end
        if (arst_n && mem_write && mem_resp) begin
            assert (mem_address != POISON_ADDR) else text_error("skipped store was written");
            assert (mem_address == exp_waddr[write_idx])
                else value_error("mem_address", mem_address, exp_waddr[write_idx]);
            assert (mem_wdata == exp_wdata[write_idx])
                else value_error("mem_wdata", mem_wdata, exp_wdata[write_idx]);
            write_idx <= write_idx + 1;
            if (write_idx == NUM_WRITES - 1) begin
                if (read_idx == NUM_READS) begin
                    $display("PASS: all tests");
                    $finish;
                end else begin
                    value_error("read count", read_idx[15:0], NUM_READS[15:0]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            text_error("timed out before final store");
        end
    end

endmodule

`default_nettype wire

// File: tb.f
common/lc3b_isa_pkg.sv
common/lc3b_ctrl_pkg.sv
datapath/alu.sv
datapath/regfile.sv
datapath/datapath.sv
hw/control.sv
hw/cpu.sv
sim/tb_memory.sv
sim/tb_cpu.sv
